/* design/dma_pkg.sv */
package dma_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;
  localparam int unsigned ID_W   = 4;

  // Register space is 256 bytes, word aligned
  localparam int unsigned REG_IDX_W = 8;

  // Channel field widths
  localparam int unsigned OFFSET_W = 8;
  localparam int unsigned REPEAT_W = 11;

  // Buffer between reader and writer
  localparam int unsigned FIFO_DEPTH = 2;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  localparam logic [REG_IDX_W-1:0] REG_SRC_ADDR  = 8'h00;
  localparam logic [REG_IDX_W-1:0] REG_DST_ADDR  = 8'h04;
  localparam logic [REG_IDX_W-1:0] REG_CONTROL   = 8'h08;
  localparam logic [REG_IDX_W-1:0] REG_INTERRUPT = 8'h10;
  localparam logic [REG_IDX_W-1:0] REG_STATUS    = 8'h14;

  // Control word layout
  localparam int unsigned CTRL_OFFSET_LSB    = 24;
  localparam int unsigned CTRL_REPEAT_LSB    = 13;
  localparam int unsigned CTRL_BYTE_MODE_BIT = 1;
  localparam int unsigned CTRL_START_BIT     = 0;

endpackage

/* design/dma_cfg_if.sv */
`timescale 1ns/1ps

interface dma_cfg_if ();

  logic [dma_pkg::ADDR_W-1:0]   src_addr;
  logic [dma_pkg::ADDR_W-1:0]   dst_addr;
  logic [dma_pkg::OFFSET_W-1:0] offset;
  logic [dma_pkg::REPEAT_W-1:0] repeat_cnt;
  logic                         byte_mode;
  // One-cycle pulses from the register block
  logic                         start;
  logic                         abort;
  logic                         busy;

  modport regs   (output src_addr, dst_addr, offset, repeat_cnt, byte_mode, start, abort,
                  input  busy);
  modport reader (input  src_addr, offset, repeat_cnt, start, abort);
  modport writer (input  dst_addr, repeat_cnt, byte_mode, start, abort,
                  output busy);

endinterface

/* design/dma_fifo_wr_if.sv */
`timescale 1ns/1ps

interface dma_fifo_wr_if ();

  logic                       wr_en;
  logic [dma_pkg::DATA_W-1:0] wr_data;
  // Occupancy flags seen by the reader
  logic                       full;
  logic                       almost_full;

  modport reader (output wr_en, wr_data,
                  input  full, almost_full);
  modport fifo   (input  wr_en, wr_data,
                  output full, almost_full);

endinterface

/* design/dma_cfg_regs.sv */
`timescale 1ns/1ps

module dma_cfg_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cfg_req_i,
  input  logic                       cfg_we_i,
  input  logic [dma_pkg::ADDR_W-1:0] cfg_addr_i,
  input  logic [dma_pkg::DATA_W-1:0] cfg_wdata_i,
  input  logic [dma_pkg::ID_W-1:0]   cfg_id_i,
  output logic                       cfg_gnt_o,
  output logic                       cfg_rvalid_o,
  output logic                       cfg_err_o,
  output logic [dma_pkg::DATA_W-1:0] cfg_rdata_o,
  output logic [dma_pkg::ID_W-1:0]   cfg_rid_o,
  dma_cfg_if.regs                    cfg
);

  // Request captured in the grant cycle
  logic                          req_q;
  logic                          we_q;
  logic [dma_pkg::ADDR_W-1:0]    addr_q;
  logic [dma_pkg::DATA_W-1:0]    wdata_q;
  logic [dma_pkg::ID_W-1:0]      id_q;
  logic [dma_pkg::REG_IDX_W-1:0] reg_idx;

  // Channel configuration
  logic [dma_pkg::ADDR_W-1:0]   src_d, src_q;
  logic [dma_pkg::ADDR_W-1:0]   dst_d, dst_q;
  logic [dma_pkg::OFFSET_W-1:0] offset_d, offset_q;
  logic [dma_pkg::REPEAT_W-1:0] repeat_d, repeat_q;
  logic                         byte_mode_d, byte_mode_q;
  logic [dma_pkg::REPEAT_W-1:0] wr_repeat;

  // --------------------------------------------------
  // Request capture and response
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= cfg_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    we_q    <= cfg_we_i;
    addr_q  <= cfg_addr_i;
    wdata_q <= cfg_wdata_i;
    id_q    <= cfg_id_i;
  end

  // Slave never stalls
  assign cfg_gnt_o    = cfg_req_i;
  assign cfg_rvalid_o = req_q;
  assign cfg_rid_o    = id_q;

  assign reg_idx   = {addr_q[dma_pkg::REG_IDX_W-1:2], 2'b00};
  assign wr_repeat = wdata_q[dma_pkg::CTRL_REPEAT_LSB +: dma_pkg::REPEAT_W];

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  always_comb begin
    src_d       = src_q;
    dst_d       = dst_q;
    offset_d    = offset_q;
    repeat_d    = repeat_q;
    byte_mode_d = byte_mode_q;
    cfg.start   = 1'b0;
    cfg.abort   = 1'b0;
    cfg_rdata_o = '0;
    cfg_err_o   = 1'b0;

    if (req_q && we_q) begin
      // Only an abort gets through while a transfer runs
      if (cfg.busy && reg_idx != dma_pkg::REG_INTERRUPT) begin
        cfg_err_o = 1'b1;
      end else begin
        case (reg_idx)
          dma_pkg::REG_SRC_ADDR: src_d = wdata_q;
          dma_pkg::REG_DST_ADDR: dst_d = wdata_q;
          dma_pkg::REG_CONTROL: begin
            if (wdata_q[dma_pkg::CTRL_START_BIT] && wr_repeat == '0) begin
              cfg_err_o = 1'b1;
            end else begin
              offset_d    = wdata_q[dma_pkg::CTRL_OFFSET_LSB +: dma_pkg::OFFSET_W];
              repeat_d    = wr_repeat;
              byte_mode_d = wdata_q[dma_pkg::CTRL_BYTE_MODE_BIT];
              cfg.start   = wdata_q[dma_pkg::CTRL_START_BIT];
            end
          end
          dma_pkg::REG_INTERRUPT: cfg.abort = 1'b1;
          default: cfg_err_o = 1'b1;
        endcase
      end
    end else if (req_q) begin
      case (reg_idx)
        dma_pkg::REG_SRC_ADDR: cfg_rdata_o = src_q;
        dma_pkg::REG_DST_ADDR: cfg_rdata_o = dst_q;
        dma_pkg::REG_CONTROL: begin
          cfg_rdata_o[dma_pkg::CTRL_OFFSET_LSB +: dma_pkg::OFFSET_W] = offset_q;
          cfg_rdata_o[dma_pkg::CTRL_REPEAT_LSB +: dma_pkg::REPEAT_W] = repeat_q;
          cfg_rdata_o[dma_pkg::CTRL_BYTE_MODE_BIT]                   = byte_mode_q;
          cfg_rdata_o[dma_pkg::CTRL_START_BIT]                       = cfg.busy;
        end
        dma_pkg::REG_STATUS: cfg_rdata_o[0] = cfg.busy;
        default: cfg_err_o = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      src_q       <= '0;
      dst_q       <= '0;
      offset_q    <= '0;
      repeat_q    <= '0;
      byte_mode_q <= 1'b0;
    end else begin
      src_q       <= src_d;
      dst_q       <= dst_d;
      offset_q    <= offset_d;
      repeat_q    <= repeat_d;
      byte_mode_q <= byte_mode_d;
    end
  end

  assign cfg.src_addr   = src_q;
  assign cfg.dst_addr   = dst_q;
  assign cfg.offset     = offset_q;
  assign cfg.repeat_cnt = repeat_q;
  assign cfg.byte_mode  = byte_mode_q;

endmodule

/* design/dma_reader.sv */
`timescale 1ns/1ps

module dma_reader (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  dma_cfg_if.reader                  cfg,
  dma_fifo_wr_if.reader              fifo,
  output logic                       rd_req_o,
  output logic [dma_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic                       rd_gnt_i,
  input  logic                       rd_rvalid_i,
  input  logic                       rd_err_i,
  input  logic [dma_pkg::DATA_W-1:0] rd_rdata_i
);

  enum logic [1:0] {R_IDLE, R_WAIT_SPACE, R_WAIT_GNT, R_WAIT_RVALID} state_q, state_d;

  logic [dma_pkg::REPEAT_W-1:0] cnt_d, cnt_q;
  logic                         req_d, req_q;
  logic                         wr_en_d, wr_en_q;
  logic [dma_pkg::DATA_W-1:0]   wr_data_q;

  // Source is a fixed peripheral word
  assign rd_addr_o = cfg.src_addr + {{(dma_pkg::ADDR_W - dma_pkg::OFFSET_W){1'b0}}, cfg.offset};
  assign rd_req_o  = req_q;

  assign fifo.wr_en   = wr_en_q;
  assign fifo.wr_data = wr_data_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    req_d   = 1'b0;
    wr_en_d = 1'b0;

    case (state_q)
      R_IDLE: begin
        if (cfg.start) begin
          state_d = R_WAIT_GNT;
          req_d   = 1'b1;
          cnt_d   = {{(dma_pkg::REPEAT_W-1){1'b0}}, 1'b1};
        end
      end
      R_WAIT_SPACE: begin
        // A word still in flight to the FIFO is not yet in its count
        if (!fifo.full && !wr_en_q) begin
          state_d = R_WAIT_GNT;
          req_d   = 1'b1;
        end
      end
      R_WAIT_GNT: begin
        if (rd_gnt_i) begin
          state_d = R_WAIT_RVALID;
        end else begin
          req_d = 1'b1;
        end
      end
      R_WAIT_RVALID: begin
        // Error responses are dropped, keep waiting
        if (rd_rvalid_i && !rd_err_i) begin
          wr_en_d = 1'b1;
          cnt_d   = cnt_q + 1'b1;
          if (cnt_q == cfg.repeat_cnt) begin
            state_d = R_IDLE;
          end else if (!fifo.almost_full) begin
            state_d = R_WAIT_GNT;
            req_d   = 1'b1;
          end else begin
            state_d = R_WAIT_SPACE;
          end
        end
      end
      default: state_d = R_IDLE;
    endcase

    if (cfg.abort) begin
      state_d = R_IDLE;
      req_d   = 1'b0;
      wr_en_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= R_IDLE;
      cnt_q   <= '0;
      req_q   <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      req_q   <= req_d;
      wr_en_q <= wr_en_d;
    end
  end

  // Qualified by wr_en_q
  always_ff @(posedge clk_i) begin
    wr_data_q <= rd_rdata_i;
  end

endmodule

/* design/dma_fifo.sv */
`timescale 1ns/1ps

module dma_fifo (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  dma_fifo_wr_if.fifo                wr,
  input  logic                       rd_en_i,
  output logic [dma_pkg::DATA_W-1:0] rd_data_o,
  output logic                       empty_o
);

  logic [dma_pkg::DATA_W-1:0]               mem_q [dma_pkg::FIFO_DEPTH];
  logic [$clog2(dma_pkg::FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(dma_pkg::FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(dma_pkg::FIFO_DEPTH+1)-1:0] count_q;
  logic                                     push;
  logic                                     pop;

  assign push = wr.wr_en && !wr.full;
  assign pop  = rd_en_i && !empty_o;

  // Flags straight from the occupancy count
  assign wr.full        = (count_q == dma_pkg::FIFO_DEPTH);
  assign wr.almost_full = (count_q >= dma_pkg::FIFO_DEPTH - 1);
  assign empty_o        = (count_q == '0);

  // First-word fall-through
  assign rd_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr.wr_data;
    end
  end

endmodule

/* design/dma_writer.sv */
`timescale 1ns/1ps

module dma_writer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  dma_cfg_if.writer                  cfg,
  output logic                       rd_en_o,
  input  logic [dma_pkg::DATA_W-1:0] rd_data_i,
  input  logic                       empty_i,
  output logic                       wr_req_o,
  output logic [dma_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [dma_pkg::BE_W-1:0]   wr_be_o,
  output logic [dma_pkg::DATA_W-1:0] wr_wdata_o,
  input  logic                       wr_gnt_i
);

  enum logic [1:0] {W_IDLE, W_WAIT_DATA, W_WAIT_GNT} state_q, state_d;

  logic [dma_pkg::REPEAT_W-1:0] cnt_d, cnt_q;
  logic                         req_d, req_q;
  logic [dma_pkg::ADDR_W-1:0]   addr_d, addr_q;
  logic [dma_pkg::BE_W-1:0]     be_d, be_q;
  logic [dma_pkg::DATA_W-1:0]   wdata_d, wdata_q;

  // Next beat, prepared from the FIFO head
  logic [dma_pkg::ADDR_W-1:0]   addr_step;
  logic [dma_pkg::ADDR_W-1:0]   next_addr;
  logic [dma_pkg::ADDR_W-1:0]   beat_addr;
  logic [dma_pkg::BE_W-1:0]     beat_be;
  logic [dma_pkg::DATA_W-1:0]   beat_data;

  assign addr_step = cfg.byte_mode ? 'd1 : 'd4;
  assign next_addr = addr_q + addr_step;
  // After a grant the next beat already uses the advanced address
  assign beat_addr = (state_q == W_WAIT_GNT) ? next_addr : addr_q;
  assign beat_be   = cfg.byte_mode ?
                     ({{(dma_pkg::BE_W-1){1'b0}}, 1'b1} << beat_addr[1:0]) : '1;
  assign beat_data = cfg.byte_mode ? {dma_pkg::BE_W{rd_data_i[7:0]}} : rd_data_i;

  assign cfg.busy = (state_q != W_IDLE);

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    req_d   = 1'b0;
    addr_d  = addr_q;
    be_d    = be_q;
    wdata_d = wdata_q;
    rd_en_o = 1'b0;

    case (state_q)
      W_IDLE: begin
        if (cfg.start) begin
          state_d = W_WAIT_DATA;
          cnt_d   = {{(dma_pkg::REPEAT_W-1){1'b0}}, 1'b1};
          addr_d  = cfg.dst_addr;
        end
      end
      W_WAIT_DATA: begin
        if (!empty_i) begin
          rd_en_o = 1'b1;
          req_d   = 1'b1;
          be_d    = beat_be;
          wdata_d = beat_data;
          state_d = W_WAIT_GNT;
        end
      end
      W_WAIT_GNT: begin
        if (wr_gnt_i) begin
          cnt_d  = cnt_q + 1'b1;
          addr_d = next_addr;
          if (cnt_q == cfg.repeat_cnt) begin
            state_d = W_IDLE;
          end else if (!empty_i) begin
            // Back-to-back beat
            rd_en_o = 1'b1;
            req_d   = 1'b1;
            be_d    = beat_be;
            wdata_d = beat_data;
          end else begin
            state_d = W_WAIT_DATA;
          end
        end else begin
          req_d = 1'b1;
        end
      end
      default: state_d = W_IDLE;
    endcase

    if (cfg.abort) begin
      state_d = W_IDLE;
      req_d   = 1'b0;
      rd_en_o = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
      cnt_q   <= '0;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      req_q   <= req_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    be_q    <= be_d;
    wdata_q <= wdata_d;
  end

  assign wr_req_o   = req_q;
  assign wr_addr_o  = addr_q;
  assign wr_be_o    = be_q;
  assign wr_wdata_o = wdata_q;

endmodule

/* design/dma_top.sv */
`timescale 1ns/1ps

module dma_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Configuration slave
  input  logic                       cfg_req_i,
  input  logic                       cfg_we_i,
  input  logic [dma_pkg::ADDR_W-1:0] cfg_addr_i,
  input  logic [dma_pkg::DATA_W-1:0] cfg_wdata_i,
  input  logic [dma_pkg::ID_W-1:0]   cfg_id_i,
  output logic                       cfg_gnt_o,
  output logic                       cfg_rvalid_o,
  output logic                       cfg_err_o,
  output logic [dma_pkg::DATA_W-1:0] cfg_rdata_o,
  output logic [dma_pkg::ID_W-1:0]   cfg_rid_o,
  // Read manager towards the peripheral
  output logic                       rd_req_o,
  output logic [dma_pkg::ADDR_W-1:0] rd_addr_o,
  input  logic                       rd_gnt_i,
  input  logic                       rd_rvalid_i,
  input  logic                       rd_err_i,
  input  logic [dma_pkg::DATA_W-1:0] rd_rdata_i,
  // Write manager towards memory
  output logic                       wr_req_o,
  output logic [dma_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [dma_pkg::BE_W-1:0]   wr_be_o,
  output logic [dma_pkg::DATA_W-1:0] wr_wdata_o,
  input  logic                       wr_gnt_i
);

  dma_cfg_if     u_cfg_if ();
  dma_fifo_wr_if u_fifo_wr_if ();

  // FIFO read side
  logic                       fifo_rd_en;
  logic [dma_pkg::DATA_W-1:0] fifo_rd_data;
  logic                       fifo_empty;

  dma_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_req_i    (cfg_req_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_id_i     (cfg_id_i),
    .cfg_gnt_o    (cfg_gnt_o),
    .cfg_rvalid_o (cfg_rvalid_o),
    .cfg_err_o    (cfg_err_o),
    .cfg_rdata_o  (cfg_rdata_o),
    .cfg_rid_o    (cfg_rid_o),
    .cfg          (u_cfg_if.regs)
  );

  dma_reader u_reader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg         (u_cfg_if.reader),
    .fifo        (u_fifo_wr_if.reader),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_gnt_i    (rd_gnt_i),
    .rd_rvalid_i (rd_rvalid_i),
    .rd_err_i    (rd_err_i),
    .rd_rdata_i  (rd_rdata_i)
  );

  dma_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr        (u_fifo_wr_if.fifo),
    .rd_en_i   (fifo_rd_en),
    .rd_data_o (fifo_rd_data),
    .empty_o   (fifo_empty)
  );

  dma_writer u_writer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg        (u_cfg_if.writer),
    .rd_en_o    (fifo_rd_en),
    .rd_data_i  (fifo_rd_data),
    .empty_i    (fifo_empty),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_be_o    (wr_be_o),
    .wr_wdata_o (wr_wdata_o),
    .wr_gnt_i   (wr_gnt_i)
  );

endmodule

/* sim/dma_top_asserts.sv */
`timescale 1ns/1ps

module dma_top_asserts (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       cfg_req_i,
  input logic                       cfg_we_i,
  input logic [dma_pkg::ADDR_W-1:0] cfg_addr_i,
  input logic                       rd_req_o,
  input logic [dma_pkg::ADDR_W-1:0] rd_addr_o,
  input logic                       rd_gnt_i,
  input logic                       wr_req_o,
  input logic [dma_pkg::ADDR_W-1:0] wr_addr_o,
  input logic [dma_pkg::BE_W-1:0]   wr_be_o,
  input logic [dma_pkg::DATA_W-1:0] wr_wdata_o,
  input logic                       wr_gnt_i,
  input logic                       busy_i
);

  // Abort pulse follows an interrupt register write by one cycle
  logic abort_q;
  // Number of failed properties
  int   fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      abort_q <= 1'b0;
    end else begin
      abort_q <= cfg_req_i && cfg_we_i &&
                 ({cfg_addr_i[dma_pkg::REG_IDX_W-1:2], 2'b00} == dma_pkg::REG_INTERRUPT);
    end
  end

  // --------------------------------------------------
  // Manager handshakes
  // --------------------------------------------------
  a_rd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_o && !rd_gnt_i && !abort_q |=> rd_req_o && $stable(rd_addr_o))
    else begin
      $error("read request dropped or changed before its grant");
      fail_cnt++;
    end

  a_wr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req_o && !wr_gnt_i && !abort_q |=>
      wr_req_o && $stable({wr_addr_o, wr_be_o, wr_wdata_o}))
    else begin
      $error("write request dropped or changed before its grant");
      fail_cnt++;
    end

  a_wr_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req_o |-> (wr_be_o == '1) || $onehot(wr_be_o))
    else begin
      $error("write byte enable neither full nor one-hot");
      fail_cnt++;
    end

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_req_o || wr_req_o) |-> busy_i)
    else begin
      $error("manager request while the engine is idle");
      fail_cnt++;
    end

endmodule

/* sim/tb_dma.sv */
`timescale 1ns/1ps

module tb_dma;

  localparam logic [31:0] SEED        = 32'hb1c2398c;
  localparam int          NUM_TESTS   = 12;
  localparam int          MAX_REPEAT  = 16;
  localparam int          TIMEOUT_CYC = NUM_TESTS * MAX_REPEAT * 40;
  localparam int          POLL_MAX    = 200;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       cfg_req_i;
  logic                       cfg_we_i;
  logic [dma_pkg::ADDR_W-1:0] cfg_addr_i;
  logic [dma_pkg::DATA_W-1:0] cfg_wdata_i;
  logic [dma_pkg::ID_W-1:0]   cfg_id_i;
  logic                       cfg_gnt_o;
  logic                       cfg_rvalid_o;
  logic                       cfg_err_o;
  logic [dma_pkg::DATA_W-1:0] cfg_rdata_o;
  logic [dma_pkg::ID_W-1:0]   cfg_rid_o;
  logic                       rd_req_o;
  logic [dma_pkg::ADDR_W-1:0] rd_addr_o;
  logic                       rd_gnt_i;
  logic                       rd_rvalid_i;
  logic                       rd_err_i;
  logic [dma_pkg::DATA_W-1:0] rd_rdata_i;
  logic                       wr_req_o;
  logic [dma_pkg::ADDR_W-1:0] wr_addr_o;
  logic [dma_pkg::BE_W-1:0]   wr_be_o;
  logic [dma_pkg::DATA_W-1:0] wr_wdata_o;
  logic                       wr_gnt_i;

  // Words handed out by the peripheral and beats granted by memory
  logic [31:0] stream_q[$];
  logic [31:0] wr_addr_log[$];
  logic [3:0]  wr_be_log[$];
  logic [31:0] wr_data_log[$];
  logic [31:0] exp_rd_addr;
  int          err_cnt;
  int          test_err_base;
  int          tests_run;
  int          tests_failed;

  dma_top u_dut (.*);

  bind dma_top dma_top_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_req_i  (cfg_req_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .rd_req_o   (rd_req_o),
    .rd_addr_o  (rd_addr_o),
    .rd_gnt_i   (rd_gnt_i),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_be_o    (wr_be_o),
    .wr_wdata_o (wr_wdata_o),
    .wr_gnt_i   (wr_gnt_i),
    .busy_i     (u_cfg_if.busy)
  );

  always #4 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // Procedural check errors plus failed bound properties
  function automatic int error_total();
    return err_cnt + u_dut.u_asserts.fail_cnt;
  endfunction

  function automatic logic [31:0] make_ctrl(input logic [7:0] offs, input logic [10:0] rep,
                                            input logic byte_mode, input logic start);
    logic [31:0] w;
    w = '0;
    w[dma_pkg::CTRL_OFFSET_LSB +: dma_pkg::OFFSET_W] = offs;
    w[dma_pkg::CTRL_REPEAT_LSB +: dma_pkg::REPEAT_W] = rep;
    w[dma_pkg::CTRL_BYTE_MODE_BIT] = byte_mode;
    w[dma_pkg::CTRL_START_BIT]     = start;
    return w;
  endfunction

  // --------------------------------------------------
  // Configuration port
  // --------------------------------------------------
  task automatic cfg_access(input logic we, input logic [7:0] offs, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    logic [3:0] id;
    id = 4'($urandom);
    @(negedge clk_i);
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = {24'($urandom), offs};
    cfg_wdata_i = wdata;
    cfg_id_i    = id;
    #1;
    check_value("cfg_gnt_o", 1'b1, cfg_gnt_o);
    check_value("cfg_rvalid_o", 1'b0, cfg_rvalid_o);
    @(negedge clk_i);
    // Response belongs to the previous cycle
    check_value("cfg_rvalid_o", 1'b1, cfg_rvalid_o);
    check_value("cfg_rid_o", id, cfg_rid_o);
    rdata     = cfg_rdata_o;
    err       = cfg_err_o;
    cfg_req_i = 1'b0;
    cfg_we_i  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] offs, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    cfg_access(1'b1, offs, wdata, rdata, err);
    check_value("cfg_err_o", exp_err, err);
  endtask

  task automatic reg_read_check(input logic [7:0] offs, input logic [31:0] exp_data,
                                input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    cfg_access(1'b0, offs, '0, rdata, err);
    check_value("cfg_err_o", exp_err, err);
    if (!exp_err) begin
      check_value("cfg_rdata_o", exp_data, rdata);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    do begin
      repeat (4) @(negedge clk_i);
      cfg_access(1'b0, dma_pkg::REG_STATUS, '0, st, err);
      polls++;
    end while (st[0] && polls < POLL_MAX);
    assert (!st[0]) else begin
      $display("%0t: transfer did not finish, status still shows busy", $time);
      err_cnt++;
    end
  endtask

  task automatic expect_no_requests(input int cycles);
    int seen;
    seen = 0;
    repeat (cycles) begin
      @(negedge clk_i);
      if (rd_req_o || wr_req_o) seen++;
    end
    assert (seen == 0) else begin
      $display("%0t: manager requests seen in %0d cycles where none belong", $time, seen);
      err_cnt++;
    end
  endtask

  task automatic start_test();
    test_err_base = error_total();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_total() - test_err_base;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errs == 0) ? "ok" : "failed");
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic run_reg_test();
    logic [31:0] src;
    logic [31:0] dst;
    logic [7:0]  offs;
    logic [10:0] rep;
    logic        bm;
    src  = $urandom;
    dst  = $urandom;
    offs = 8'($urandom);
    rep  = 11'($urandom);
    bm   = 1'($urandom);
    check_value("rd_req_o", 1'b0, rd_req_o);
    check_value("wr_req_o", 1'b0, wr_req_o);
    reg_write(dma_pkg::REG_SRC_ADDR, src, 1'b0);
    reg_write(dma_pkg::REG_DST_ADDR, dst, 1'b0);
    reg_write(dma_pkg::REG_CONTROL, make_ctrl(offs, rep, bm, 1'b0), 1'b0);
    reg_read_check(dma_pkg::REG_SRC_ADDR, src, 1'b0);
    reg_read_check(dma_pkg::REG_DST_ADDR, dst, 1'b0);
    reg_read_check(dma_pkg::REG_CONTROL, make_ctrl(offs, rep, bm, 1'b0), 1'b0);
    reg_read_check(dma_pkg::REG_STATUS, '0, 1'b0);
    // Unmapped offsets, and the write-only and read-only registers
    reg_write(8'h0c, $urandom, 1'b1);
    reg_write(dma_pkg::REG_STATUS, $urandom, 1'b1);
    reg_write(8'h40, $urandom, 1'b1);
    reg_read_check(8'h0c, '0, 1'b1);
    reg_read_check(dma_pkg::REG_INTERRUPT, '0, 1'b1);
    reg_read_check(8'hfc, '0, 1'b1);
  endtask

  task automatic run_transfer(input logic byte_mode, input logic poke_busy);
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] word;
    logic [31:0] exp_addr;
    logic [7:0]  offs;
    logic [10:0] rep;
    int          base;
    int          n;
    src  = $urandom;
    dst  = $urandom;
    offs = 8'($urandom);
    rep  = poke_busy ? 11'(MAX_REPEAT) : 11'($urandom_range(MAX_REPEAT, 1));
    if (!byte_mode) dst[1:0] = 2'b00;
    exp_rd_addr = src + {24'h0, offs};
    reg_write(dma_pkg::REG_SRC_ADDR, src, 1'b0);
    reg_write(dma_pkg::REG_DST_ADDR, dst, 1'b0);
    wr_addr_log.delete();
    wr_be_log.delete();
    wr_data_log.delete();
    base = stream_q.size();
    reg_write(dma_pkg::REG_CONTROL, make_ctrl(offs, rep, byte_mode, 1'b1), 1'b0);
    if (poke_busy) begin
      reg_write(dma_pkg::REG_SRC_ADDR, ~src, 1'b1);
      reg_write(dma_pkg::REG_CONTROL, make_ctrl(~offs, 11'd3, ~byte_mode, 1'b1), 1'b1);
      reg_read_check(dma_pkg::REG_SRC_ADDR, src, 1'b0);
    end
    wait_idle();
    assert (wr_addr_log.size() == rep) else begin
      $display("%0t: expected %0d write beats, memory saw %0d", $time, rep, wr_addr_log.size());
      err_cnt++;
    end
    assert (stream_q.size() - base == rep) else begin
      $display("%0t: expected %0d source reads, peripheral served %0d", $time, rep,
               stream_q.size() - base);
      err_cnt++;
    end
    n = (wr_addr_log.size() < rep) ? wr_addr_log.size() : rep;
    for (int k = 0; k < n && base + k < stream_q.size(); k++) begin
      word = stream_q[base + k];
      if (byte_mode) begin
        exp_addr = dst + k;
        check_value("wr_addr_o", exp_addr, wr_addr_log[k]);
        check_value("wr_be_o", 4'b0001 << exp_addr[1:0], wr_be_log[k]);
        check_value("wr_wdata_o", {4{word[7:0]}}, wr_data_log[k]);
      end else begin
        check_value("wr_addr_o", dst + 4 * k, wr_addr_log[k]);
        check_value("wr_be_o", 4'hf, wr_be_log[k]);
        check_value("wr_wdata_o", word, wr_data_log[k]);
      end
    end
  endtask

  task automatic run_abort();
    int i;
    exp_rd_addr = $urandom;
    reg_write(dma_pkg::REG_SRC_ADDR, exp_rd_addr, 1'b0);
    reg_write(dma_pkg::REG_DST_ADDR, {30'($urandom), 2'b00}, 1'b0);
    wr_addr_log.delete();
    reg_write(dma_pkg::REG_CONTROL, make_ctrl(8'h00, 11'(MAX_REPEAT), 1'b0, 1'b1), 1'b0);
    for (i = 0; i < 500 && wr_addr_log.size() < 2; i++) @(negedge clk_i);
    reg_write(dma_pkg::REG_INTERRUPT, '0, 1'b0);
    @(negedge clk_i);
    expect_no_requests(30);
    assert (wr_addr_log.size() < MAX_REPEAT) else begin
      $display("%0t: transfer ran to completion despite the abort", $time);
      err_cnt++;
    end
    reg_read_check(dma_pkg::REG_STATUS, '0, 1'b0);
  endtask

  task automatic run_zero_repeat();
    reg_write(dma_pkg::REG_CONTROL, make_ctrl(8'($urandom), 11'd0, 1'b0, 1'b1), 1'b1);
    expect_no_requests(20);
    reg_read_check(dma_pkg::REG_STATUS, '0, 1'b0);
  endtask

  // --------------------------------------------------
  // Peripheral and memory responders
  // --------------------------------------------------
  initial begin : read_responder
    logic [31:0] word;
    rd_gnt_i    = 1'b0;
    rd_rvalid_i = 1'b0;
    rd_err_i    = 1'b0;
    rd_rdata_i  = '0;
    forever begin
      @(negedge clk_i);
      rd_rvalid_i = 1'b0;
      rd_err_i    = 1'b0;
      if (rd_req_o) begin
        repeat ($urandom_range(3, 0)) @(negedge clk_i);
        // An abort may have withdrawn the request meanwhile
        if (rd_req_o) begin
          check_value("rd_addr_o", exp_rd_addr, rd_addr_o);
          rd_gnt_i = 1'b1;
          @(negedge clk_i);
          rd_gnt_i = 1'b0;
          repeat ($urandom_range(2, 0)) @(negedge clk_i);
          if ($urandom_range(3, 0) == 0) begin
            rd_rvalid_i = 1'b1;
            rd_err_i    = 1'b1;
            rd_rdata_i  = $urandom;
            @(negedge clk_i);
            rd_err_i = 1'b0;
          end
          word = $urandom;
          stream_q.push_back(word);
          rd_rvalid_i = 1'b1;
          rd_rdata_i  = word;
        end
      end
    end
  end

  initial begin : write_responder
    wr_gnt_i = 1'b0;
    forever begin
      @(negedge clk_i);
      wr_gnt_i = 1'b0;
      if (wr_req_o) begin
        repeat ($urandom_range(3, 0)) @(negedge clk_i);
        if (wr_req_o) begin
          wr_gnt_i = 1'b1;
          wr_addr_log.push_back(wr_addr_o);
          wr_be_log.push_back(wr_be_o);
          wr_data_log.push_back(wr_wdata_o);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles before the tests completed", TIMEOUT_CYC);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    logic [31:0] seed_val;
    seed_val     = $urandom(SEED);
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cfg_req_i    = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    cfg_id_i     = '0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test();
    run_reg_test();
    finish_test("register access");
    for (int i = 0; i < 4; i++) begin
      start_test();
      run_transfer(1'b0, 1'b0);
      finish_test("word transfer");
    end
    for (int i = 0; i < 4; i++) begin
      start_test();
      run_transfer(1'b1, 1'b0);
      finish_test("byte transfer");
    end
    start_test();
    run_transfer(1'b0, 1'b1);
    finish_test("writes while busy");
    start_test();
    run_abort();
    finish_test("abort");
    start_test();
    run_zero_repeat();
    finish_test("zero repeat start");

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, error_total());
    if (error_total() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* dma_top.f */
design/dma_pkg.sv
design/dma_cfg_if.sv
design/dma_fifo_wr_if.sv
design/dma_cfg_regs.sv
design/dma_reader.sv
design/dma_fifo.sv
design/dma_writer.sv
design/dma_top.sv
sim/dma_top_asserts.sv
sim/tb_dma.sv
